//--- Bender.yml
package:
  name: alu_unit

sources:
  - files:
      - design/alu_pkg.sv
      - design/cond_eval.sv
      - design/alu_lo_stage.sv
      - design/alu_hi_stage.sv
      - design/alu_unit.sv
  - target: simulation
    files:
      - sim/tb_clkgen.sv
      - sim/alu_unit_sva.sv
      - sim/alu_unit_tb.sv

//--- design/alu_hi_stage.sv
// second stage: high half, flag generation and output registers
// a failed condition returns operand a with the incoming flags untouched
`timescale 1ns/1ps

module alu_hi_stage #(
  parameter int data_w = 64
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                s1_valid,
  input  logic                s1_take,
  input  alu_pkg::op_t        s1_op,
  input  logic [data_w-1:0]   s1_a,
  input  logic [data_w-1:0]   s1_b,
  input  logic [data_w/2-1:0] s1_lo,
  input  logic                s1_carry,
  input  logic                s1_lo_zero,
  input  alu_pkg::flags_t     s1_flags,
  output logic                res_valid,
  output logic                res_write,
  output logic [data_w-1:0]   result,
  output alu_pkg::flags_t     flags_out
);

  localparam int hw   = data_w / 2;
  localparam int sh_w = $clog2(data_w);

  logic              sub_op;
  logic              arith_op;
  logic [hw-1:0]     a_hi;
  logic [hw-1:0]     b_hi_x;
  logic [hw:0]       sum_hi;
  logic [data_w-1:0] shifted;
  logic [hw-1:0]     hi_res;
  logic [data_w-1:0] full_res;
  alu_pkg::flags_t   new_flags;

  assign sub_op   = (s1_op == alu_pkg::op_sub);
  assign arith_op = (s1_op == alu_pkg::op_add) | sub_op;

  assign a_hi   = s1_a[data_w-1:hw];
  assign b_hi_x = s1_b[data_w-1:hw] ^ {hw{sub_op}};
  assign sum_hi = {1'b0, a_hi} + {1'b0, b_hi_x} + {{hw{1'b0}}, s1_carry};

  always_comb begin
    case (s1_op)
      alu_pkg::op_sll: shifted = s1_a << s1_b[sh_w-1:0];
      alu_pkg::op_srl: shifted = s1_a >> s1_b[sh_w-1:0];
      default:         shifted = $signed(s1_a) >>> s1_b[sh_w-1:0];
    endcase
  end

  always_comb begin
    case (s1_op)
      alu_pkg::op_add,
      alu_pkg::op_sub: hi_res = sum_hi[hw-1:0];
      alu_pkg::op_and: hi_res = a_hi & s1_b[data_w-1:hw];
      alu_pkg::op_or:  hi_res = a_hi | s1_b[data_w-1:hw];
      alu_pkg::op_xor: hi_res = a_hi ^ s1_b[data_w-1:hw];
      alu_pkg::op_sll,
      alu_pkg::op_srl,
      alu_pkg::op_sra: hi_res = shifted[data_w-1:hw];
      default:         hi_res = s1_b[data_w-1:hw];
    endcase
  end

  assign full_res = {hi_res, s1_lo};

  always_comb begin
    new_flags = '0;
    new_flags[alu_pkg::flag_c] = arith_op & sum_hi[hw]; // no borrow on sub
    // signed overflow: same-sign inputs, result sign differs
    new_flags[alu_pkg::flag_v] = arith_op & (a_hi[hw-1] == b_hi_x[hw-1]) &
                                 (sum_hi[hw-1] != a_hi[hw-1]);
    new_flags[alu_pkg::flag_s] = hi_res[hw-1];
    new_flags[alu_pkg::flag_z] = s1_lo_zero & ~|hi_res;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      res_write <= 1'b0;
    end else begin
      res_valid <= s1_valid;
      res_write <= s1_valid & s1_take;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      result    <= s1_take ? full_res : s1_a;
      flags_out <= s1_take ? new_flags : s1_flags;
    end
  end

endmodule

//--- design/alu_lo_stage.sv
// first stage: operand select, condition test and the low half of the result
// s1 payload only loads on issue, so it holds the last issued op otherwise
`timescale 1ns/1ps

module alu_lo_stage #(
  parameter int data_w = 64
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                issue,
  input  alu_pkg::op_t        op,
  input  alu_pkg::cond_t      cond,
  input  alu_pkg::flags_t     flags_in,
  input  logic [data_w-1:0]   a,
  input  logic [data_w-1:0]   b,
  input  logic [data_w-1:0]   imm,
  input  logic                use_imm,
  output logic                s1_valid,
  output logic                s1_take,
  output alu_pkg::op_t        s1_op,
  output logic [data_w-1:0]   s1_a,
  output logic [data_w-1:0]   s1_b,
  output logic [data_w/2-1:0] s1_lo,
  output logic                s1_carry,
  output logic                s1_lo_zero,
  output alu_pkg::flags_t     s1_flags
);

  localparam int hw   = data_w / 2;
  localparam int sh_w = $clog2(data_w);

  logic [data_w-1:0] b_eff;
  logic [data_w-1:0] shifted;
  logic              sub_in;
  logic [hw-1:0]     b_lo_x;
  logic [hw:0]       sum_lo;
  logic [hw-1:0]     lo_res;
  logic              take;

  assign b_eff = use_imm ? imm : b;

  cond_eval u_cond (
    .cond  (cond),
    .flags (flags_in),
    .take  (take)
  );

  // sub is a + ~b + 1, the +1 enters at the low half only
  assign sub_in = (op == alu_pkg::op_sub);
  assign b_lo_x = b_eff[hw-1:0] ^ {hw{sub_in}};
  assign sum_lo = {1'b0, a[hw-1:0]} + {1'b0, b_lo_x} + {{hw{1'b0}}, sub_in};

  always_comb begin
    case (op)
      alu_pkg::op_sll: shifted = a << b_eff[sh_w-1:0];
      alu_pkg::op_srl: shifted = a >> b_eff[sh_w-1:0];
      default:         shifted = $signed(a) >>> b_eff[sh_w-1:0];
    endcase
  end

  always_comb begin
    case (op)
      alu_pkg::op_add,
      alu_pkg::op_sub: lo_res = sum_lo[hw-1:0];
      alu_pkg::op_and: lo_res = a[hw-1:0] & b_eff[hw-1:0];
      alu_pkg::op_or:  lo_res = a[hw-1:0] | b_eff[hw-1:0];
      alu_pkg::op_xor: lo_res = a[hw-1:0] ^ b_eff[hw-1:0];
      alu_pkg::op_sll,
      alu_pkg::op_srl,
      alu_pkg::op_sra: lo_res = shifted[hw-1:0]; // low half of full shift
      default:         lo_res = b_eff[hw-1:0];   // mov and spare codes
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s1_take  <= 1'b0;
    end else begin
      s1_valid <= issue;
      s1_take  <= issue & take;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      s1_op      <= op;
      s1_a       <= a;
      s1_b       <= b_eff;
      s1_lo      <= lo_res;
      s1_carry   <= sum_lo[hw]; // only meaningful for add/sub
      s1_lo_zero <= ~|lo_res;
      s1_flags   <= flags_in;
    end
  end

endmodule

//--- design/alu_pkg.sv
// shared codes for the two-stage integer execution unit
// data width must be even and a power of two so the shift amount fits
package alu_pkg;

  parameter int data_w_default = 64;

  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1, // a + ~b + 1
    op_and = 4'd2,
    op_or  = 4'd3,
    op_xor = 4'd4,
    op_sll = 4'd5,
    op_srl = 4'd6,
    op_sra = 4'd7,
    op_mov = 4'd8  // codes 9..15 decode as mov
  } op_t;

  typedef enum logic [3:0] {
    cond_eq = 4'd0,
    cond_ne = 4'd1,
    cond_cs = 4'd2,
    cond_cc = 4'd3,
    cond_mi = 4'd4,
    cond_pl = 4'd5,
    cond_vs = 4'd6,
    cond_vc = 4'd7,
    cond_hi = 4'd8,  // c and not z
    cond_ls = 4'd9,
    cond_ge = 4'd10, // s == v
    cond_lt = 4'd11,
    cond_gt = 4'd12,
    cond_le = 4'd13,
    cond_al = 4'd14,
    cond_nv = 4'd15
  } cond_t;

  // carry, overflow, sign, zero from msb down
  typedef logic [3:0] flags_t;

  parameter int flag_c = 3;
  parameter int flag_v = 2;
  parameter int flag_s = 1;
  parameter int flag_z = 0;

endpackage

//--- design/alu_unit.sv
// two-stage execution unit, one issue per cycle, no back-pressure
// result appears two clock edges after the issue edge
`timescale 1ns/1ps

module alu_unit #(
  parameter int data_w = alu_pkg::data_w_default
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              issue,
  input  alu_pkg::op_t      op,
  input  alu_pkg::cond_t    cond,
  input  alu_pkg::flags_t   flags_in,
  input  logic [data_w-1:0] a,
  input  logic [data_w-1:0] b,
  input  logic [data_w-1:0] imm,
  input  logic              use_imm,
  output logic              res_valid,
  output logic              res_write,
  output logic [data_w-1:0] result,
  output alu_pkg::flags_t   flags_out
);

  logic                s1_valid;
  logic                s1_take;
  alu_pkg::op_t        s1_op;
  logic [data_w-1:0]   s1_a;
  logic [data_w-1:0]   s1_b;
  logic [data_w/2-1:0] s1_lo;
  logic                s1_carry;
  logic                s1_lo_zero;
  alu_pkg::flags_t     s1_flags;

  alu_lo_stage #(.data_w(data_w)) u_lo (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .op         (op),
    .cond       (cond),
    .flags_in   (flags_in),
    .a          (a),
    .b          (b),
    .imm        (imm),
    .use_imm    (use_imm),
    .s1_valid   (s1_valid),
    .s1_take    (s1_take),
    .s1_op      (s1_op),
    .s1_a       (s1_a),
    .s1_b       (s1_b),
    .s1_lo      (s1_lo),
    .s1_carry   (s1_carry),
    .s1_lo_zero (s1_lo_zero),
    .s1_flags   (s1_flags)
  );

  alu_hi_stage #(.data_w(data_w)) u_hi (
    .clk        (clk),
    .rst        (rst),
    .s1_valid   (s1_valid),
    .s1_take    (s1_take),
    .s1_op      (s1_op),
    .s1_a       (s1_a),
    .s1_b       (s1_b),
    .s1_lo      (s1_lo),
    .s1_carry   (s1_carry),
    .s1_lo_zero (s1_lo_zero),
    .s1_flags   (s1_flags),
    .res_valid  (res_valid),
    .res_write  (res_write),
    .result     (result),
    .flags_out  (flags_out)
  );

endmodule

//--- design/cond_eval.sv
// condition test of a 4-bit code against a flag word, purely combinational
`timescale 1ns/1ps

module cond_eval (
  input  alu_pkg::cond_t  cond,
  input  alu_pkg::flags_t flags,
  output logic            take
);

  logic c;
  logic v;
  logic s;
  logic z;
  logic hi;
  logic ge;
  logic gt;

  assign c = flags[alu_pkg::flag_c];
  assign v = flags[alu_pkg::flag_v];
  assign s = flags[alu_pkg::flag_s];
  assign z = flags[alu_pkg::flag_z];

  assign hi = c & ~z;    // unsigned higher
  assign ge = (s == v);
  assign gt = ~z & ge;

  always_comb begin
    case (cond)
      alu_pkg::cond_eq: take = z;
      alu_pkg::cond_ne: take = ~z;
      alu_pkg::cond_cs: take = c;
      alu_pkg::cond_cc: take = ~c;
      alu_pkg::cond_mi: take = s;
      alu_pkg::cond_pl: take = ~s;
      alu_pkg::cond_vs: take = v;
      alu_pkg::cond_vc: take = ~v;
      alu_pkg::cond_hi: take = hi;
      alu_pkg::cond_ls: take = ~hi;
      alu_pkg::cond_ge: take = ge;
      alu_pkg::cond_lt: take = ~ge;
      alu_pkg::cond_gt: take = gt;
      alu_pkg::cond_le: take = ~gt;
      alu_pkg::cond_al: take = 1'b1;
      default:          take = 1'b0; // nv
    endcase
  end

endmodule

//--- list.f
design/alu_pkg.sv
design/cond_eval.sv
design/alu_lo_stage.sv
design/alu_hi_stage.sv
design/alu_unit.sv
sim/tb_clkgen.sv
sim/alu_unit_sva.sv
sim/alu_unit_tb.sv

//--- sim/alu_unit_sva.sv
// strobe timing and reset checks, bound into every alu_unit instance
`timescale 1ns/1ps

module alu_unit_sva (
  input logic clk,
  input logic rst,
  input logic issue,
  input logic res_valid,
  input logic res_write
);

  // issue edge E0, result registered at E1, seen at E2
  a_valid_latency: assert property (@(posedge clk) disable iff (rst) issue |-> ##2 res_valid)
    else $error("res_valid missing two edges after issue");

  a_write_in_valid: assert property (@(posedge clk) disable iff (rst) res_write |-> res_valid)
    else $error("res_write high without res_valid");

  a_quiet_in_reset: assert property (@(posedge clk) rst |=> !res_valid && !res_write)
    else $error("output strobe high during reset");

endmodule

bind alu_unit alu_unit_sva u_sva (
  .clk       (clk),
  .rst       (rst),
  .issue     (issue),
  .res_valid (res_valid),
  .res_write (res_write)
);

//--- sim/alu_unit_tb.sv
// alu_unit testbench with LFSR stimulus, a reference model and in-order compare
// assumes data_w of 64 for the shift sweep and the cycle limit
`timescale 1ns/1ps

module alu_unit_tb;

  localparam int data_w  = alu_pkg::data_w_default;
  localparam int sh_w    = $clog2(data_w);
  localparam int n_tests = 6;
  // arith, logic, shift, cond, back-to-back, reset
  localparam int n_issue = 40 + 40 + 3 * data_w + 16 * 4 + 200 + 1;
  localparam int max_cycles = 2 + 2 + n_issue + 3 * n_tests + 20; // reset, idle, drains
  localparam logic [3:0] logic_ops [4] = '{alu_pkg::op_and, alu_pkg::op_or,
                                           alu_pkg::op_xor, alu_pkg::op_mov};

  typedef struct packed {
    logic [2:0]        tid;
    logic              take;
    logic [data_w-1:0] res;
    logic [3:0]        fl;
  } exp_t;

  logic              clk;
  logic              rst;
  logic              issue;
  alu_pkg::op_t      op;
  alu_pkg::cond_t    cond;
  alu_pkg::flags_t   flags_in;
  logic [data_w-1:0] a;
  logic [data_w-1:0] b;
  logic [data_w-1:0] imm;
  logic              use_imm;
  logic              res_valid;
  logic              res_write;
  logic [data_w-1:0] result;
  alu_pkg::flags_t   flags_out;

  exp_t              exp_q[$];
  logic [31:0]       lfsr = 32'hac53b8a6;
  logic [data_w-1:0] ra;
  logic [data_w-1:0] rb;
  logic [data_w-1:0] ri;
  logic [3:0]        rop;
  logic [3:0]        rcond;
  logic [3:0]        rfl;
  logic              ruse;
  string             test_name [n_tests];
  int                issued [n_tests];
  int                checked [n_tests];
  int                errors [n_tests];
  int                other_errors;
  int                total_errors;
  int                total_checked;
  int                cycles;

  tb_clkgen clkgen (.clk(clk), .rst(rst));

  alu_unit #(.data_w(data_w)) UUT (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .op        (op),
    .cond      (cond),
    .flags_in  (flags_in),
    .a         (a),
    .b         (b),
    .imm       (imm),
    .use_imm   (use_imm),
    .res_valid (res_valid),
    .res_write (res_write),
    .result    (result),
    .flags_out (flags_out)
  );

  // taps x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [data_w-1:0] rand_bits(input int n);
    logic [data_w-1:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      val  = {val[data_w-2:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic void alu_ref(
    input  logic [3:0]        op_i,
    input  logic [3:0]        cond_i,
    input  logic [3:0]        fl_i,
    input  logic [data_w-1:0] a_i,
    input  logic [data_w-1:0] b_i,
    output logic              take_o,
    output logic [data_w-1:0] res_o,
    output logic [3:0]        fl_o
  );
    logic            c;
    logic            v;
    logic            s;
    logic            z;
    logic            arith;
    logic [data_w:0] wide;
    logic [sh_w-1:0] amt;
    c = fl_i[alu_pkg::flag_c];
    v = fl_i[alu_pkg::flag_v];
    s = fl_i[alu_pkg::flag_s];
    z = fl_i[alu_pkg::flag_z];
    case (cond_i)
      4'd0:    take_o = z;
      4'd1:    take_o = !z;
      4'd2:    take_o = c;
      4'd3:    take_o = !c;
      4'd4:    take_o = s;
      4'd5:    take_o = !s;
      4'd6:    take_o = v;
      4'd7:    take_o = !v;
      4'd8:    take_o = c && !z;
      4'd9:    take_o = !c || z;
      4'd10:   take_o = (s == v);
      4'd11:   take_o = (s != v);
      4'd12:   take_o = !z && (s == v);
      4'd13:   take_o = z || (s != v);
      4'd14:   take_o = 1'b1;
      default: take_o = 1'b0;
    endcase
    amt   = b_i[sh_w-1:0];
    arith = (op_i == alu_pkg::op_add) || (op_i == alu_pkg::op_sub);
    case (op_i)
      alu_pkg::op_add: wide = {1'b0, a_i} + {1'b0, b_i};
      alu_pkg::op_sub: wide = {1'b0, a_i} + {1'b0, ~b_i} + 1; // carry means no borrow
      alu_pkg::op_and: wide = {1'b0, a_i & b_i};
      alu_pkg::op_or:  wide = {1'b0, a_i | b_i};
      alu_pkg::op_xor: wide = {1'b0, a_i ^ b_i};
      alu_pkg::op_sll: wide = {1'b0, a_i << amt};
      alu_pkg::op_srl: wide = {1'b0, a_i >> amt};
      alu_pkg::op_sra: wide = {1'b0, $signed(a_i) >>> amt};
      default:         wide = {1'b0, b_i};
    endcase
    if (take_o) begin
      res_o = wide[data_w-1:0];
      fl_o  = '0;
      fl_o[alu_pkg::flag_c] = arith && wide[data_w];
      if (op_i == alu_pkg::op_add)
        fl_o[alu_pkg::flag_v] = (a_i[data_w-1] == b_i[data_w-1]) &&
                                (res_o[data_w-1] != a_i[data_w-1]);
      else if (op_i == alu_pkg::op_sub)
        fl_o[alu_pkg::flag_v] = (a_i[data_w-1] != b_i[data_w-1]) &&
                                (res_o[data_w-1] != a_i[data_w-1]);
      fl_o[alu_pkg::flag_s] = res_o[data_w-1];
      fl_o[alu_pkg::flag_z] = (res_o == '0);
    end else begin
      res_o = a_i; // a passes through on a failed condition
      fl_o  = fl_i;
    end
  endfunction

  task automatic send(input int tid, input logic [3:0] op_i, input logic [3:0] cond_i,
                      input logic [3:0] fl_i, input logic [data_w-1:0] a_i,
                      input logic [data_w-1:0] b_i, input logic [data_w-1:0] imm_i,
                      input logic use_imm_i);
    exp_t e;
    @(posedge clk);
    #1;
    issue    = 1'b1;
    op       = alu_pkg::op_t'(op_i);
    cond     = alu_pkg::cond_t'(cond_i);
    flags_in = fl_i;
    a        = a_i;
    b        = b_i;
    imm      = imm_i;
    use_imm  = use_imm_i;
    e.tid    = tid[2:0];
    alu_ref(op_i, cond_i, fl_i, a_i, use_imm_i ? imm_i : b_i, e.take, e.res, e.fl);
    exp_q.push_back(e);
    issued[tid]++;
  endtask

  task automatic drain_and_report(input int tid);
    @(posedge clk);
    #1;
    issue = 1'b0;
    while (exp_q.size() != 0)
      @(posedge clk);
    if (checked[tid] != issued[tid]) begin
      $display("%s: %0d issued but %0d results came back", test_name[tid],
               issued[tid], checked[tid]);
      errors[tid]++;
    end
    $display("test %-6s done: %0d results, %0d errors", test_name[tid], checked[tid],
             errors[tid]);
  endtask

  task automatic report_mismatch(input int tid, input string field,
                                 input logic [data_w-1:0] exp_v,
                                 input logic [data_w-1:0] act_v);
    $display("[ERROR] %s %s: expected %h, actual %h", test_name[tid], field, exp_v, act_v);
    errors[tid]++;
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk) begin : compare
    exp_t e;
    if (res_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("res_valid pulsed at %0t with no operation outstanding", $time);
        other_errors++;
      end else begin
        e = exp_q.pop_front();
        checked[e.tid]++;
        if (res_write !== e.take)
          report_mismatch(e.tid, "res_write", e.take, res_write);
        if (result !== e.res)
          report_mismatch(e.tid, "result", e.res, result);
        if (flags_out !== e.fl)
          report_mismatch(e.tid, "flags_out", e.fl, flags_out);
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("run stopped after %0d cycles with %0d results outstanding", cycles,
               exp_q.size());
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    issue     = 1'b1; // held high while rst is asserted
    op        = alu_pkg::op_add;
    cond      = alu_pkg::cond_al;
    flags_in  = '0;
    a         = '0;
    b         = '0;
    imm       = '0;
    use_imm   = 1'b0;
    test_name = '{"arith", "logic", "shift", "cond", "b2b", "reset"};

    // quiet outputs after reset, then a single add
    wait (rst == 1'b0);
    issue = 1'b0;
    repeat (2) begin
      @(negedge clk);
      if (res_valid !== 1'b0)
        report_mismatch(5, "res_valid", '0, res_valid);
      if (res_write !== 1'b0)
        report_mismatch(5, "res_write", '0, res_write);
    end
    ra = rand_bits(data_w);
    rb = rand_bits(data_w);
    send(5, alu_pkg::op_add, alu_pkg::cond_al, 4'h0, ra, rb, '0, 1'b0);
    drain_and_report(5);

    for (int i = 0; i < 40; i++) begin
      ra  = rand_bits(data_w);
      rb  = rand_bits(data_w);
      rfl = rand_bits(4);
      case (i % 5)
        1: ra[data_w/2-1:0] = '1; // carry into the high half
        2: begin
          ra = {1'b0, {(data_w-1){1'b1}}};
          rb = 1;
        end
        3: rb = ra;
        4: ra[data_w/2-1:0] = '0; // borrow across the halves
        default: ;
      endcase
      send(0, i[0] ? alu_pkg::op_sub : alu_pkg::op_add, alu_pkg::cond_al, rfl, ra, rb, '0,
           1'b0);
    end
    drain_and_report(0);

    for (int i = 0; i < 40; i++) begin
      ra  = rand_bits(data_w);
      rb  = rand_bits(data_w);
      ri  = rand_bits(data_w);
      rfl = rand_bits(4);
      if (i % 8 == 4)
        ra = '0; // zero result on and
      send(1, logic_ops[i % 4], alu_pkg::cond_al, rfl, ra, rb, ri, i[2]);
    end
    drain_and_report(1);

    for (int s = 0; s < 3; s++) begin
      for (int amt = 0; amt < data_w; amt++) begin
        ra  = rand_bits(data_w);
        rb  = rand_bits(data_w);
        rfl = rand_bits(4);
        ra[data_w-1]   = amt[0];
        rb[sh_w-1:0]   = amt[sh_w-1:0]; // upper bits must be ignored
        send(2, 4'(int'(alu_pkg::op_sll) + s), alu_pkg::cond_al, rfl, ra,
             amt[1] ? ~rb : rb, rb, amt[1]);
      end
    end
    drain_and_report(2);

    for (int c = 0; c < 16; c++) begin
      repeat (4) begin
        ra  = rand_bits(data_w);
        rb  = rand_bits(data_w);
        rop = rand_bits(4);
        rfl = rand_bits(4);
        send(3, rop, 4'(c), rfl, ra, rb, '0, 1'b0);
      end
    end
    drain_and_report(3);

    repeat (200) begin
      ra    = rand_bits(data_w);
      rb    = rand_bits(data_w);
      ri    = rand_bits(data_w);
      rop   = rand_bits(4);
      rcond = rand_bits(4);
      rfl   = rand_bits(4);
      ruse  = rand_bits(1);
      send(4, rop, rcond, rfl, ra, rb, ri, ruse);
    end
    drain_and_report(4);

    if (exp_q.size() != 0) begin
      $display("%0d expected results were never returned", exp_q.size());
      other_errors++;
    end
    total_errors = other_errors;
    for (int t = 0; t < n_tests; t++) begin
      total_errors  += errors[t];
      total_checked += checked[t];
    end
    $display("summary: %0d tests, %0d results checked, %0d errors", n_tests, total_checked,
             total_errors);
    if (total_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- sim/tb_clkgen.sv
// 20 ns clock, reset held high over the first two rising edges
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0; // released just after the second edge
  end

endmodule
